// File: bench/fetch_stage_tb.sv
/*
 * Testbench for the fetch stage top
 * Clock, reset, one-cycle instruction memory model fed from the vector image
 * Random stall and redirect, issue checks against the vector columns
 */

`include "fetch_cfg.svh"

module fetch_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 32;               // Image size, repeats every 128 bytes
    localparam int COLS  = 7;                // addr word class rd rs1 rs2 imm
    localparam int DEPTH = `FETCH_IB_DEPTH;

    logic                          clk;
    logic                          rst_n;
    logic                          imem_req;
    fetch_types_pkg::addr_t        imem_addr;
    logic                          imem_rvalid;
    fetch_types_pkg::instr_t       imem_rdata;
    logic                          fetch_en;
    logic                          issue_stall;
    logic                          redirect;
    fetch_types_pkg::addr_t        redirect_pc;
    logic                          issue_valid;
    fetch_types_pkg::addr_t        issue_pc;
    fetch_types_pkg::instr_class_e issue_class;
    fetch_types_pkg::reg_idx_t     issue_rd;
    fetch_types_pkg::reg_idx_t     issue_rs1;
    fetch_types_pkg::reg_idx_t     issue_rs2;
    fetch_types_pkg::imm_t         issue_imm;

    logic [31:0]            vec [WORDS*COLS]; // Flat vector image
    logic [31:0]            rnd;              // LCG state
    fetch_types_pkg::addr_t exp_pc;           // Next PC due at issue
    int                     issue_count;
    int                     redirect_count;
    int                     held;             // Words in the buffer or in flight
    bit                     fetch_on;
    bit                     stall_force;      // Hold the head to fill the buffer
    bit                     stall_rand;
    bit                     redir_rand;
    bit                     expect_idle;      // Cycle after a redirect

    fetch_stage_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rvalid (imem_rvalid),
        .imem_rdata  (imem_rdata),
        .fetch_en    (fetch_en),
        .issue_stall (issue_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_class (issue_class),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_imm   (issue_imm)
    );

    always #10 clk = ~clk; // 20 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Vector line of a byte address, image wraps
    function automatic int word_index(input fetch_types_pkg::addr_t a);
        return int'((a >> 2) % WORDS);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    // Control strobes all low
    task automatic expect_quiet(input string when);
        check_value(32'(imem_req), 32'd0, {"imem_req ", when});
        check_value(32'(issue_valid), 32'd0, {"issue_valid ", when});
        check_value(32'(u_dut.ib_push), 32'd0, {"ib_push ", when});
        check_value(32'(u_dut.ib_pop), 32'd0, {"ib_pop ", when});
    endtask

    // Word memory, answer exactly one cycle after each request
    always @(posedge clk) begin
        imem_rvalid <= imem_req;
        imem_rdata  <= vec[word_index(imem_addr) * COLS + 1];
    end

    // Called on the rising edge
    task automatic drive_controls();
        rnd = lcg_next(rnd);
        fetch_en    <= fetch_on;
        issue_stall <= stall_force || (stall_rand && rnd[18:16] < 3'd5); // ~5/8 stalled
        if (redir_rand && !redirect && rnd[23:20] == 4'd0) begin
            redirect    <= 1'b1;                         // Single-cycle pulse
            redirect_pc <= vec[int'(rnd[31:27]) * COLS]; // Target from the image
        end else begin
            redirect <= 1'b0;
        end
    endtask

    // Called on the falling edge, outputs settled
    task automatic monitor_issue();
        int base;
        base = word_index(issue_pc) * COLS;
        if (expect_idle) begin
            check_value(32'(issue_valid), 32'd0, "issue_valid after redirect");
            expect_idle = 1'b0;
        end
        if (issue_valid) begin
            check_value(issue_pc, exp_pc, "issue_pc");   // Gap, repeat or stale word
            check_value(32'(issue_class), vec[base + 2], "issue_class");
            check_value(32'(issue_rd), vec[base + 3], "issue_rd");
            check_value(32'(issue_rs1), vec[base + 4], "issue_rs1");
            check_value(32'(issue_rs2), vec[base + 5], "issue_rs2");
            check_value(issue_imm, vec[base + 6], "issue_imm");
            exp_pc = exp_pc + 32'd4;
            issue_count++;
        end
        if (redirect) begin
            exp_pc = redirect_pc; // Stream restarts here
            expect_idle = 1'b1;
            held = 0;             // Buffer flushed, in-flight word dropped
            redirect_count++;
        end else begin
            held = held + int'(imem_req) - int'(issue_valid);
            check_value(32'(held <= DEPTH), 32'd1, "words held within buffer depth");
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        drive_controls();
        @(negedge clk);
        monitor_issue();
    endtask

    task automatic run_until(input bit on_redirects, input int target, input int limit,
                             input string what);
        int cycles;
        cycles = 0;
        while ((on_redirects ? redirect_count : issue_count) < target) begin
            if (cycles >= limit)
                fail_run($sformatf("timeout: %s not reached within %0d cycles", what, limit));
            step_cycle();
            cycles++;
        end
    endtask

    initial begin
        int i;
        int cycles;
        clk         = 1'b0;
        rst_n       <= 1'b0;
        fetch_en    <= 1'b0;
        issue_stall <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        imem_rvalid <= 1'b0;
        imem_rdata  <= '0;
        rnd            = 32'd15294;
        exp_pc         = `FETCH_RESET_PC;
        issue_count    = 0;
        redirect_count = 0;
        held           = 0;
        fetch_on       = 1'b0;
        stall_force    = 1'b0;
        stall_rand     = 1'b0;
        redir_rand     = 1'b0;
        expect_idle    = 1'b0;

        $readmemh("bench/fetch_vectors.txt", vec);
        for (i = 0; i < WORDS; i++)
            check_value(vec[i * COLS], 32'(i * 4), "vector file address column");

        repeat (3) begin // Reset cycles
            @(negedge clk);
            expect_quiet("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_quiet("after reset");

        // First request, then issue two cycles later
        fetch_on = 1'b1;
        cycles = 0;
        while (!imem_req) begin
            if (cycles >= 10)
                fail_run("timeout: no memory request after fetch_en was raised");
            step_cycle();
            cycles++;
        end
        check_value(imem_addr, `FETCH_RESET_PC, "first imem_addr");
        check_value(32'(issue_valid), 32'd0, "issue_valid at first request");
        step_cycle();
        check_value(32'(issue_valid), 32'd0, "issue_valid one cycle after first request");
        step_cycle();
        check_value(32'(issue_valid), 32'd1, "issue_valid two cycles after first request");

        run_until(1'b0, 40, 200, "40 issues without stall"); // Crosses the image wrap

        // Held stall, buffer fills and fetch pauses
        stall_force = 1'b1;
        repeat (DEPTH + 4) step_cycle();
        check_value(32'(u_dut.ib_early_full), 32'd1, "early_full under held stall");
        check_value(32'(imem_req), 32'd0, "imem_req under held stall");
        stall_force = 1'b0;

        stall_rand = 1'b1;
        run_until(1'b0, issue_count + 80, 1000, "80 issues under random stall");

        redir_rand = 1'b1;
        run_until(1'b1, 8, 3000, "8 redirects");
        redir_rand = 1'b0;
        stall_rand = 1'b0;
        run_until(1'b0, issue_count + 8, 200, "8 issues after the last redirect");

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: bench/fetch_vectors.txt
// Instruction image, one word per line; class code follows instr_class_e order (0 alu_imm .. 9 illegal)
// addr word class rd rs1 rs2 imm, all hex
00000000 00500093 0 01 00 05 00000005
00000004 FFF08113 0 02 01 1F FFFFFFFF
00000008 002081B3 1 03 01 02 00000000
0000000C 40218233 1 04 03 02 00000000
00000010 00812283 2 05 02 08 00000008
00000014 FFC0A303 2 06 01 1C FFFFFFFC
00000018 00512623 3 0C 02 05 0000000C
0000001C FE60AC23 3 18 01 06 FFFFFFF8
00000020 00208863 4 10 01 02 00000010
00000024 FE019CE3 4 19 03 00 FFFFFFF8
00000028 014000EF 5 01 00 14 00000014
0000002C FFDFF06F 5 00 1F 1D FFFFFFFC
00000030 000280E7 6 01 05 00 00000000
00000034 FF008067 6 00 01 10 FFFFFFF0
00000038 123453B7 7 07 08 03 12345000
0000003C 00001417 8 08 00 00 00001000
00000040 00000000 9 00 00 00 00000000
00000044 FFFFFFFF 9 1F 1F 1F 00000000
00000048 00004501 9 0A 00 00 00000000
0000004C 00349493 0 09 09 03 00000003
00000050 00C5C533 1 0A 0B 0C 00000000
00000054 7FF74683 2 0D 0E 1F 000007FF
00000058 80F80023 3 00 10 0F FFFFF800
0000005C 7F28CFE3 4 1F 11 12 00000FFE
00000060 001002EF 5 05 00 01 00000800
00000064 FFFFFF97 8 1F 1F 1F FFFFF000
00000068 80000037 7 00 00 00 80000000
0000006C 0000007B 9 00 00 00 00000000
00000070 016AEA33 1 14 15 16 00000000
00000074 7F7C1FA3 3 1F 18 17 000007FF
00000078 0F0D7C93 0 19 1A 10 000000F0
0000007C 81FF7063 4 00 1E 1F FFFFF000

// File: hw/fetch_stage_top.sv
/*
 * Front end top
 * Fetch unit, instruction buffer and decoder chain
 */

module fetch_stage_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // Instruction memory
    output logic                         imem_req,
    output fetch_types_pkg::addr_t        imem_addr,
    input  logic                         imem_rvalid,
    input  fetch_types_pkg::instr_t       imem_rdata,
    // Control
    input  logic                         fetch_en,
    input  logic                         issue_stall,
    input  logic                         redirect,
    input  fetch_types_pkg::addr_t        redirect_pc,
    // Issue
    output logic                         issue_valid,
    output fetch_types_pkg::addr_t        issue_pc,
    output fetch_types_pkg::instr_class_e issue_class,
    output fetch_types_pkg::reg_idx_t     issue_rd,
    output fetch_types_pkg::reg_idx_t     issue_rs1,
    output fetch_types_pkg::reg_idx_t     issue_rs2,
    output fetch_types_pkg::imm_t         issue_imm
);

    logic                    ib_push;
    fetch_types_pkg::addr_t  ib_push_pc;
    fetch_types_pkg::instr_t ib_push_instr;
    logic                    ib_early_full;
    logic                    ib_pop;
    logic                    head_valid;
    fetch_types_pkg::addr_t  head_pc;
    fetch_types_pkg::instr_t head_instr;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_en      (fetch_en),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_rvalid   (imem_rvalid),
        .imem_rdata    (imem_rdata),
        .early_full    (ib_early_full),
        .ib_push       (ib_push),
        .ib_push_pc    (ib_push_pc),
        .ib_push_instr (ib_push_instr)
    );

    instruction_buffer u_ibuf (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),   // Redirect empties the queue
        .push       (ib_push),
        .push_pc    (ib_push_pc),
        .push_instr (ib_push_instr),
        .pop        (ib_pop),
        .head_valid (head_valid),
        .head_pc    (head_pc),
        .head_instr (head_instr),
        .full       (),           // Checked inside the buffer
        .early_full (ib_early_full)
    );

    instruction_decoder u_decode (
        .head_valid  (head_valid),
        .head_pc     (head_pc),
        .head_instr  (head_instr),
        .issue_stall (issue_stall),
        .pop         (ib_pop),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_class (issue_class),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_imm   (issue_imm)
    );

endmodule

// File: hw/fetch_types_pkg.sv
/*
 * Front end types
 * Address, instruction, register index, immediate and opcode vectors
 * Instruction class and fetch FSM state enums
 */

package fetch_types_pkg;

    typedef logic [31:0] addr_t;    // Byte address of an instruction
    typedef logic [31:0] instr_t;   // Raw RV32I word
    typedef logic [4:0]  reg_idx_t; // rd / rs1 / rs2
    typedef logic [31:0] imm_t;     // Sign-extended immediate
    typedef logic [6:0]  opcode_t;  // instr[6:0]

    // Decoder classification, one per RV32I base opcode group
    typedef enum logic [3:0] {
        cls_alu_imm,
        cls_alu_reg,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_illegal
    } instr_class_e;

    // Fetch unit FSM
    typedef enum logic {
        fs_idle,  // Waiting for fetch_en
        fs_fetch  // Requests allowed
    } fetch_state_e;

endpackage

// File: hw/fetch_unit.sv
/*
 * Fetch unit with PC, memory request strobe and in-flight tracking
 * Discards the stale answer on redirect, pushes words into the buffer
 */

`include "fetch_cfg.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  logic                   redirect,
    input  fetch_types_pkg::addr_t  redirect_pc,
    output logic                   imem_req,
    output fetch_types_pkg::addr_t  imem_addr,
    input  logic                   imem_rvalid,
    input  fetch_types_pkg::instr_t imem_rdata,
    input  logic                   early_full,
    output logic                   ib_push,
    output fetch_types_pkg::addr_t  ib_push_pc,
    output fetch_types_pkg::instr_t ib_push_instr
);

    fetch_types_pkg::fetch_state_e state_q;
    fetch_types_pkg::addr_t        pc_q;      // Next address to request
    fetch_types_pkg::addr_t        pend_pc_q; // Address of the outstanding request
    logic                          inflight_q; // Answer due this cycle
    logic                          discard_q;  // That answer is stale

    // FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_types_pkg::fs_idle;
        end else begin
            case (state_q)
                fetch_types_pkg::fs_idle:
                    if (fetch_en)
                        state_q <= fetch_types_pkg::fs_fetch;
                fetch_types_pkg::fs_fetch:
                    if (!fetch_en)
                        state_q <= fetch_types_pkg::fs_idle;
                default:
                    state_q <= fetch_types_pkg::fs_idle;
            endcase
        end
    end

    // At most one answer in flight, so early_full leaves room for it
    assign imem_req  = (state_q == fetch_types_pkg::fs_fetch) && !early_full;
    assign imem_addr = pc_q;

    // PC, redirect has priority over sequential advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (imem_req) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // In-flight and discard tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight_q <= 1'b0;
            discard_q  <= 1'b0;
        end else begin
            inflight_q <= imem_req;
            discard_q  <= redirect & imem_req; // Request made on the old path
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req)
            pend_pc_q <= pc_q; // Paired with the word next cycle
    end

    // Answer landing in the redirect cycle is stale too
    assign ib_push       = imem_rvalid && inflight_q && !discard_q && !redirect;
    assign ib_push_pc    = pend_pc_q;
    assign ib_push_instr = imem_rdata;

    // Memory answers exactly one cycle after each request
    a_rvalid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        imem_rvalid |-> inflight_q)
        else $error("fetch_unit: imem_rvalid without request in previous cycle");

    a_req_answered: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |=> imem_rvalid)
        else $error("fetch_unit: request not answered after one cycle");

endmodule

// File: hw/instruction_buffer.sv
/*
 * Circular instruction buffer of PC and word pairs
 * One-hot occupancy vector drives full, early_full and head_valid
 */

`include "fetch_cfg.svh"

module instruction_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   push,
    input  fetch_types_pkg::addr_t  push_pc,
    input  fetch_types_pkg::instr_t push_instr,
    input  logic                   pop,
    output logic                   head_valid,
    output fetch_types_pkg::addr_t  head_pc,
    output fetch_types_pkg::instr_t head_instr,
    output logic                   full,
    output logic                   early_full
);

    localparam int DEPTH = `FETCH_IB_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
        $error("FETCH_IB_DEPTH must be a power of two, at least 2");
    end

    fetch_types_pkg::addr_t  pc_mem    [DEPTH]; // Ring storage
    fetch_types_pkg::instr_t instr_mem [DEPTH];

    logic [IDX_W-1:0] write_idx; // Push side only
    logic [IDX_W-1:0] read_idx;  // Pop side only
    logic [DEPTH:0]   occ;       // Bit n set when n entries held

    // Indices wrap naturally at DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_idx <= '0;
            read_idx  <= '0;
        end else if (flush) begin
            write_idx <= '0;
            read_idx  <= '0;
        end else begin
            if (push)
                write_idx <= write_idx + 1'b1;
            if (pop)
                read_idx <= read_idx + 1'b1;
        end
    end

    // Occupancy shift, unchanged when push and pop coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= {{DEPTH{1'b0}}, 1'b1};
        end else if (flush) begin
            occ <= {{DEPTH{1'b0}}, 1'b1};
        end else if (push && !pop) begin
            occ <= {occ[DEPTH-1:0], 1'b0}; // One more
        end else if (pop && !push) begin
            occ <= {1'b0, occ[DEPTH:1]};   // One less
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[write_idx]    <= push_pc;
            instr_mem[write_idx] <= push_instr;
        end
    end

    assign head_valid = ~occ[0];
    assign head_pc    = pc_mem[read_idx];
    assign head_instr = instr_mem[read_idx];
    assign full       = occ[DEPTH];
    assign early_full = occ[DEPTH-1] | occ[DEPTH]; // One slot or none left

    // Fetch throttling must keep the in-flight word within capacity
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full))
        else $error("instruction_buffer: push while full");

    // Decoder may only pop a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && !head_valid))
        else $error("instruction_buffer: pop while empty");

endmodule

// File: hw/instruction_decoder.sv
/*
 * RV32I decoder on the buffer head
 * Field split, immediate build, classification and pop strobe
 */

module instruction_decoder (
    input  logic                         head_valid,
    input  fetch_types_pkg::addr_t        head_pc,
    input  fetch_types_pkg::instr_t       head_instr,
    input  logic                         issue_stall,
    output logic                         pop,
    output logic                         issue_valid,
    output fetch_types_pkg::addr_t        issue_pc,
    output fetch_types_pkg::instr_class_e issue_class,
    output fetch_types_pkg::reg_idx_t     issue_rd,
    output fetch_types_pkg::reg_idx_t     issue_rs1,
    output fetch_types_pkg::reg_idx_t     issue_rs2,
    output fetch_types_pkg::imm_t         issue_imm
);

    // RV32I base opcodes
    localparam fetch_types_pkg::opcode_t OP_LOAD   = 7'b0000011;
    localparam fetch_types_pkg::opcode_t OP_ALU_I  = 7'b0010011;
    localparam fetch_types_pkg::opcode_t OP_AUIPC  = 7'b0010111;
    localparam fetch_types_pkg::opcode_t OP_STORE  = 7'b0100011;
    localparam fetch_types_pkg::opcode_t OP_ALU_R  = 7'b0110011;
    localparam fetch_types_pkg::opcode_t OP_LUI    = 7'b0110111;
    localparam fetch_types_pkg::opcode_t OP_BRANCH = 7'b1100011;
    localparam fetch_types_pkg::opcode_t OP_JALR   = 7'b1100111;
    localparam fetch_types_pkg::opcode_t OP_JAL    = 7'b1101111;

    fetch_types_pkg::opcode_t opcode;
    fetch_types_pkg::imm_t    imm_i;
    fetch_types_pkg::imm_t    imm_s;
    fetch_types_pkg::imm_t    imm_b;
    fetch_types_pkg::imm_t    imm_u;
    fetch_types_pkg::imm_t    imm_j;

    assign opcode = head_instr[6:0];

    // Register fields are passed raw for every class
    assign issue_rd  = head_instr[11:7];
    assign issue_rs1 = head_instr[19:15];
    assign issue_rs2 = head_instr[24:20];

    // Immediate formats, sign from bit 31
    assign imm_i = {{20{head_instr[31]}}, head_instr[31:20]};
    assign imm_s = {{20{head_instr[31]}}, head_instr[31:25], head_instr[11:7]};
    assign imm_b = {{19{head_instr[31]}}, head_instr[31], head_instr[7],
                    head_instr[30:25], head_instr[11:8], 1'b0};
    assign imm_u = {head_instr[31:12], 12'b0};
    assign imm_j = {{11{head_instr[31]}}, head_instr[31], head_instr[19:12],
                    head_instr[20], head_instr[30:21], 1'b0};

    // Classification by opcode only
    always_comb begin
        if (opcode[1:0] != 2'b11) begin
            issue_class = fetch_types_pkg::cls_illegal; // Compressed space
        end else begin
            case (opcode)
                OP_ALU_I:  issue_class = fetch_types_pkg::cls_alu_imm;
                OP_ALU_R:  issue_class = fetch_types_pkg::cls_alu_reg;
                OP_LOAD:   issue_class = fetch_types_pkg::cls_load;
                OP_STORE:  issue_class = fetch_types_pkg::cls_store;
                OP_BRANCH: issue_class = fetch_types_pkg::cls_branch;
                OP_JAL:    issue_class = fetch_types_pkg::cls_jal;
                OP_JALR:   issue_class = fetch_types_pkg::cls_jalr;
                OP_LUI:    issue_class = fetch_types_pkg::cls_lui;
                OP_AUIPC:  issue_class = fetch_types_pkg::cls_auipc;
                default:   issue_class = fetch_types_pkg::cls_illegal;
            endcase
        end
    end

    // Immediate select follows the class
    always_comb begin
        case (issue_class)
            fetch_types_pkg::cls_alu_imm,
            fetch_types_pkg::cls_load,
            fetch_types_pkg::cls_jalr:   issue_imm = imm_i;
            fetch_types_pkg::cls_store:  issue_imm = imm_s;
            fetch_types_pkg::cls_branch: issue_imm = imm_b;
            fetch_types_pkg::cls_jal:    issue_imm = imm_j;
            fetch_types_pkg::cls_lui,
            fetch_types_pkg::cls_auipc:  issue_imm = imm_u;
            default:                     issue_imm = '0; // alu_reg, illegal
        endcase
    end

    // Issue when head present and downstream ready
    assign issue_valid = head_valid && !issue_stall;
    assign issue_pc    = head_pc;
    assign pop         = issue_valid; // Head leaves on the issuing edge

endmodule

// File: include/fetch_cfg.svh
/*
 * Front end build constants
 * Instruction buffer depth and reset fetch address
 */

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Buffer entries, power of two and at least 2
`define FETCH_IB_DEPTH 4

// First word fetched after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: run_sim.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module fetch_stage_tb

if ./obj_dir/Vfetch_stage_tb | tee /dev/stderr | grep -x "TEST PASS" > /dev/null; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verilog.f
+incdir+include
hw/fetch_types_pkg.sv
hw/instruction_buffer.sv
hw/fetch_unit.sv
hw/instruction_decoder.sv
hw/fetch_stage_top.sv
bench/fetch_stage_tb.sv
